//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes, bits 6..2
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;

    // 32-bit encodings only
    localparam logic [1:0] OPC_FULL = 2'b11;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_FENCE, OP_FENCE_I,
        OP_INVALID
    } rv_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC_P4
    } res_src_e;

    typedef enum logic {
        OP1_REG,
        OP1_PC
    } op1_sel_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  funct3;
        word_t    raw;
    } instr_fields_t;

    typedef struct packed {
        alu_op_e  alu_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        res_src_e res_src;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     jump;
        logic     branch;
        logic     pc_sel;
        funct3_t  funct3;
    } decode_ctrl_t;

endpackage

//--- hdl/rv_instr_latch.sv
`timescale 1ns/1ps

module rv_instr_latch
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  rv_decode_pkg::word_t i_instr,
    input  rv_decode_pkg::pc_t   i_pc,
    output rv_decode_pkg::word_t o_instr,
    output rv_decode_pkg::pc_t   o_pc
);

    rv_decode_pkg::word_t instr_q;
    rv_decode_pkg::pc_t   pc_q;

    // flush wins over stall, zero word decodes as a bubble
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            instr_q <= '0;
            pc_q    <= '0;
        end
        else if (!i_stall)
        begin
            instr_q <= i_instr;
            pc_q    <= i_pc;
        end
    end

    assign o_instr = instr_q;
    assign o_pc    = pc_q;

    // a flushed slot never carries an instruction into decode
    assert property (@(posedge i_clk) i_flush |=> (o_instr == '0))
        else $error("rv_instr_latch: word not cleared after flush");

endmodule

//--- hdl/rv_instr_classify.sv
`timescale 1ns/1ps

module rv_instr_classify
(
    input  rv_decode_pkg::word_t         i_instr,
    output rv_decode_pkg::rv_op_e        o_op,
    output rv_decode_pkg::instr_fields_t o_fields
);

    logic [4:0]             opcode;
    rv_decode_pkg::funct3_t funct3;
    logic [6:0]             funct7;

    assign opcode = i_instr[6:2];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    always_comb
    begin
        o_op = rv_decode_pkg::OP_INVALID;
        if (i_instr == '0)
            o_op = rv_decode_pkg::OP_NONE;
        else if (i_instr[1:0] == rv_decode_pkg::OPC_FULL)
        begin
            case (opcode)
                rv_decode_pkg::OPC_LOAD:
                    case (funct3)
                        3'b000: o_op = rv_decode_pkg::OP_LB;
                        3'b001: o_op = rv_decode_pkg::OP_LH;
                        3'b010: o_op = rv_decode_pkg::OP_LW;
                        3'b100: o_op = rv_decode_pkg::OP_LBU;
                        3'b101: o_op = rv_decode_pkg::OP_LHU;
                        default: o_op = rv_decode_pkg::OP_INVALID;
                    endcase
                rv_decode_pkg::OPC_STORE:
                    case (funct3)
                        3'b000: o_op = rv_decode_pkg::OP_SB;
                        3'b001: o_op = rv_decode_pkg::OP_SH;
                        3'b010: o_op = rv_decode_pkg::OP_SW;
                        default: o_op = rv_decode_pkg::OP_INVALID;
                    endcase
                rv_decode_pkg::OPC_OP_IMM:
                    case (funct3)
                        3'b000: o_op = rv_decode_pkg::OP_ADDI;
                        3'b001: o_op = rv_decode_pkg::OP_SLLI;
                        3'b010: o_op = rv_decode_pkg::OP_SLTI;
                        3'b011: o_op = rv_decode_pkg::OP_SLTIU;
                        3'b100: o_op = rv_decode_pkg::OP_XORI;
                        3'b110: o_op = rv_decode_pkg::OP_ORI;
                        3'b111: o_op = rv_decode_pkg::OP_ANDI;
                        default:
                        begin
                            // shift right, funct7 picks logical or arithmetic
                            if (funct7 == rv_decode_pkg::F7_BASE)
                                o_op = rv_decode_pkg::OP_SRLI;
                            else if (funct7 == rv_decode_pkg::F7_ALT)
                                o_op = rv_decode_pkg::OP_SRAI;
                        end
                    endcase
                rv_decode_pkg::OPC_OP:
                    if (funct7 == rv_decode_pkg::F7_BASE)
                    begin
                        case (funct3)
                            3'b000: o_op = rv_decode_pkg::OP_ADD;
                            3'b001: o_op = rv_decode_pkg::OP_SLL;
                            3'b010: o_op = rv_decode_pkg::OP_SLT;
                            3'b011: o_op = rv_decode_pkg::OP_SLTU;
                            3'b100: o_op = rv_decode_pkg::OP_XOR;
                            3'b101: o_op = rv_decode_pkg::OP_SRL;
                            3'b110: o_op = rv_decode_pkg::OP_OR;
                            default: o_op = rv_decode_pkg::OP_AND;
                        endcase
                    end
                    else if (funct7 == rv_decode_pkg::F7_ALT)
                    begin
                        if (funct3 == 3'b000)
                            o_op = rv_decode_pkg::OP_SUB;
                        else if (funct3 == 3'b101)
                            o_op = rv_decode_pkg::OP_SRA;
                    end
                rv_decode_pkg::OPC_BRANCH:
                    case (funct3)
                        3'b000: o_op = rv_decode_pkg::OP_BEQ;
                        3'b001: o_op = rv_decode_pkg::OP_BNE;
                        3'b100: o_op = rv_decode_pkg::OP_BLT;
                        3'b101: o_op = rv_decode_pkg::OP_BGE;
                        3'b110: o_op = rv_decode_pkg::OP_BLTU;
                        3'b111: o_op = rv_decode_pkg::OP_BGEU;
                        default: o_op = rv_decode_pkg::OP_INVALID;
                    endcase
                rv_decode_pkg::OPC_MISC_MEM:
                    if (funct3 == 3'b000)
                        o_op = rv_decode_pkg::OP_FENCE;
                    else if (funct3 == 3'b001)
                        o_op = rv_decode_pkg::OP_FENCE_I;
                rv_decode_pkg::OPC_JALR:
                    if (funct3 == 3'b000)
                        o_op = rv_decode_pkg::OP_JALR;
                rv_decode_pkg::OPC_LUI:   o_op = rv_decode_pkg::OP_LUI;
                rv_decode_pkg::OPC_AUIPC: o_op = rv_decode_pkg::OP_AUIPC;
                rv_decode_pkg::OPC_JAL:   o_op = rv_decode_pkg::OP_JAL;
                default:                  o_op = rv_decode_pkg::OP_INVALID;
            endcase
        end
    end

    // lui reads no register
    always_comb
    begin
        o_fields.rd     = i_instr[11:7];
        o_fields.rs1    = (o_op == rv_decode_pkg::OP_LUI) ? '0 : i_instr[19:15];
        o_fields.rs2    = i_instr[24:20];
        o_fields.funct3 = funct3;
        o_fields.raw    = i_instr;
    end

endmodule

//--- hdl/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
    input  rv_decode_pkg::rv_op_e i_op,
    input  rv_decode_pkg::word_t  i_instr,
    output rv_decode_pkg::word_t  o_imm
);

    always_comb
    begin
        case (i_op)
            // j-type
            rv_decode_pkg::OP_JAL:
                o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            // u-type
            rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC:
                o_imm = {i_instr[31:12], 12'b0};
            // i-type
            rv_decode_pkg::OP_JALR,
            rv_decode_pkg::OP_LB, rv_decode_pkg::OP_LH, rv_decode_pkg::OP_LW,
            rv_decode_pkg::OP_LBU, rv_decode_pkg::OP_LHU,
            rv_decode_pkg::OP_ADDI, rv_decode_pkg::OP_SLTI, rv_decode_pkg::OP_SLTIU,
            rv_decode_pkg::OP_XORI, rv_decode_pkg::OP_ORI, rv_decode_pkg::OP_ANDI,
            rv_decode_pkg::OP_SLLI, rv_decode_pkg::OP_SRLI, rv_decode_pkg::OP_SRAI:
                o_imm = {{21{i_instr[31]}}, i_instr[30:20]};
            // b-type
            rv_decode_pkg::OP_BEQ, rv_decode_pkg::OP_BNE, rv_decode_pkg::OP_BLT,
            rv_decode_pkg::OP_BGE, rv_decode_pkg::OP_BLTU, rv_decode_pkg::OP_BGEU:
                o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
            // s-type
            rv_decode_pkg::OP_SB, rv_decode_pkg::OP_SH, rv_decode_pkg::OP_SW:
                o_imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
            default:
                o_imm = '0;
        endcase
    end

endmodule

//--- hdl/rv_ctrl_gen.sv
`timescale 1ns/1ps

module rv_ctrl_gen
(
    input  rv_decode_pkg::rv_op_e        i_op,
    input  rv_decode_pkg::funct3_t       i_funct3,
    output rv_decode_pkg::decode_ctrl_t  o_ctrl,
    output logic                         o_inv_instr
);

    logic                   is_load;
    logic                   is_store;
    logic                   is_alu_imm;
    logic                   is_alu_reg;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_upper;
    rv_decode_pkg::alu_op_e alu_op;

    // instruction groups
    assign is_load    = i_op inside {rv_decode_pkg::OP_LB, rv_decode_pkg::OP_LH,
                                     rv_decode_pkg::OP_LW, rv_decode_pkg::OP_LBU,
                                     rv_decode_pkg::OP_LHU};
    assign is_store   = i_op inside {rv_decode_pkg::OP_SB, rv_decode_pkg::OP_SH,
                                     rv_decode_pkg::OP_SW};
    assign is_alu_imm = i_op inside {[rv_decode_pkg::OP_ADDI : rv_decode_pkg::OP_SRAI]};
    assign is_alu_reg = i_op inside {[rv_decode_pkg::OP_ADD : rv_decode_pkg::OP_AND]};
    assign is_branch  = i_op inside {[rv_decode_pkg::OP_BEQ : rv_decode_pkg::OP_BGEU]};
    assign is_jal     = (i_op == rv_decode_pkg::OP_JAL);
    assign is_jalr    = (i_op == rv_decode_pkg::OP_JALR);
    assign is_upper   = i_op inside {rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC};

    always_comb
    begin
        case (i_op)
            rv_decode_pkg::OP_BEQ:  alu_op = rv_decode_pkg::ALU_EQ;
            rv_decode_pkg::OP_BNE:  alu_op = rv_decode_pkg::ALU_NE;
            rv_decode_pkg::OP_BGE:  alu_op = rv_decode_pkg::ALU_GE;
            rv_decode_pkg::OP_BGEU: alu_op = rv_decode_pkg::ALU_GEU;
            rv_decode_pkg::OP_BLT, rv_decode_pkg::OP_SLT, rv_decode_pkg::OP_SLTI:
                alu_op = rv_decode_pkg::ALU_LT;
            rv_decode_pkg::OP_BLTU, rv_decode_pkg::OP_SLTU, rv_decode_pkg::OP_SLTIU:
                alu_op = rv_decode_pkg::ALU_LTU;
            rv_decode_pkg::OP_SUB:  alu_op = rv_decode_pkg::ALU_SUB;
            rv_decode_pkg::OP_XOR, rv_decode_pkg::OP_XORI:
                alu_op = rv_decode_pkg::ALU_XOR;
            rv_decode_pkg::OP_OR, rv_decode_pkg::OP_ORI:
                alu_op = rv_decode_pkg::ALU_OR;
            rv_decode_pkg::OP_AND, rv_decode_pkg::OP_ANDI:
                alu_op = rv_decode_pkg::ALU_AND;
            rv_decode_pkg::OP_SLL, rv_decode_pkg::OP_SLLI:
                alu_op = rv_decode_pkg::ALU_SLL;
            rv_decode_pkg::OP_SRL, rv_decode_pkg::OP_SRLI:
                alu_op = rv_decode_pkg::ALU_SRL;
            rv_decode_pkg::OP_SRA, rv_decode_pkg::OP_SRAI:
                alu_op = rv_decode_pkg::ALU_SRA;
            // address and upper-immediate math
            default:
                alu_op = rv_decode_pkg::ALU_ADD;
        endcase
    end

    always_comb
    begin
        o_ctrl.alu_op  = alu_op;
        o_ctrl.op1_sel = (i_op == rv_decode_pkg::OP_AUIPC || is_jal) ?
                         rv_decode_pkg::OP1_PC : rv_decode_pkg::OP1_REG;
        o_ctrl.op2_sel = (is_upper || is_jal || is_jalr || is_alu_imm || is_load || is_store) ?
                         rv_decode_pkg::OP2_IMM : rv_decode_pkg::OP2_REG;
        if (is_load)
            o_ctrl.res_src = rv_decode_pkg::RES_MEM;
        else if (is_jal || is_jalr)
            o_ctrl.res_src = rv_decode_pkg::RES_PC_P4;
        else
            o_ctrl.res_src = rv_decode_pkg::RES_ALU;
        o_ctrl.reg_write = is_load || is_alu_imm || is_alu_reg || is_upper || is_jal || is_jalr;
        o_ctrl.mem_read  = is_load;
        o_ctrl.mem_write = is_store;
        o_ctrl.jump      = is_jal || is_jalr;
        o_ctrl.branch    = is_branch;
        o_ctrl.pc_sel    = is_jalr;
        o_ctrl.funct3    = i_funct3;
    end

    assign o_inv_instr = (i_op == rv_decode_pkg::OP_INVALID);

    // sampled on every op change
    assert property (@(i_op) !(o_ctrl.mem_read && o_ctrl.mem_write))
        else $error("rv_ctrl_gen: mem_read and mem_write both high");

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  rv_decode_pkg::word_t        i_instr,
    input  rv_decode_pkg::pc_t          i_pc,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::reg_idx_t     o_rs2,
    output rv_decode_pkg::reg_idx_t     o_rd,
    output rv_decode_pkg::pc_t          o_pc,
    output rv_decode_pkg::word_t        o_imm,
    output rv_decode_pkg::decode_ctrl_t o_ctrl,
    output logic                        o_inv_instr
);

    rv_decode_pkg::word_t         instr;
    rv_decode_pkg::rv_op_e        op;
    rv_decode_pkg::instr_fields_t fields;

    rv_instr_latch rv_instr_latch_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .o_instr (instr),
        .o_pc    (o_pc)
    );

    rv_instr_classify rv_instr_classify_inst (
        .i_instr  (instr),
        .o_op     (op),
        .o_fields (fields)
    );

    rv_imm_gen rv_imm_gen_inst (
        .i_op    (op),
        .i_instr (fields.raw),
        .o_imm   (o_imm)
    );

    rv_ctrl_gen rv_ctrl_gen_inst (
        .i_op        (op),
        .i_funct3    (fields.funct3),
        .o_ctrl      (o_ctrl),
        .o_inv_instr (o_inv_instr)
    );

    assign o_rs1 = fields.rs1;
    assign o_rs2 = fields.rs2;
    assign o_rd  = fields.rd;

endmodule

//--- sim/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'h2ffd;
localparam logic [31:0] LCG_MUL  = 32'd1664525;
localparam logic [31:0] LCG_INC  = 32'd1013904223;

logic [31:0] rng_state;

// one rv32i table entry
typedef struct packed {
    logic [4:0] opc;
    logic       use_f3;
    logic [2:0] f3;
    logic       use_f7;
    logic [6:0] f7;
} op_fmt_t;

// low lcg bits cycle fast so only upper halves are used
function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    rng_state = rng_state * LCG_MUL + LCG_INC;
    hi = rng_state[31:16];
    rng_state = rng_state * LCG_MUL + LCG_INC;
    return {hi, rng_state[31:16]};
endfunction

function automatic op_fmt_t opc_only(input logic [4:0] code);
    return '{code, 1'b0, 3'd0, 1'b0, 7'd0};
endfunction

function automatic op_fmt_t with_f3(input logic [4:0] code, input logic [2:0] f3v);
    return '{code, 1'b1, f3v, 1'b0, 7'd0};
endfunction

function automatic op_fmt_t with_f7(input logic [4:0] code, input logic [2:0] f3v,
                                    input logic alt);
    return '{code, 1'b1, f3v, 1'b1,
             alt ? rv_decode_pkg::F7_ALT : rv_decode_pkg::F7_BASE};
endfunction

function automatic op_fmt_t op_fmt(input rv_decode_pkg::rv_op_e op);
    op_fmt_t f;
    case (op)
        rv_decode_pkg::OP_LB:      f = with_f3(rv_decode_pkg::OPC_LOAD, 3'd0);
        rv_decode_pkg::OP_LH:      f = with_f3(rv_decode_pkg::OPC_LOAD, 3'd1);
        rv_decode_pkg::OP_LW:      f = with_f3(rv_decode_pkg::OPC_LOAD, 3'd2);
        rv_decode_pkg::OP_LBU:     f = with_f3(rv_decode_pkg::OPC_LOAD, 3'd4);
        rv_decode_pkg::OP_LHU:     f = with_f3(rv_decode_pkg::OPC_LOAD, 3'd5);
        rv_decode_pkg::OP_SB:      f = with_f3(rv_decode_pkg::OPC_STORE, 3'd0);
        rv_decode_pkg::OP_SH:      f = with_f3(rv_decode_pkg::OPC_STORE, 3'd1);
        rv_decode_pkg::OP_SW:      f = with_f3(rv_decode_pkg::OPC_STORE, 3'd2);
        rv_decode_pkg::OP_ADDI:    f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd0);
        rv_decode_pkg::OP_SLTI:    f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd2);
        rv_decode_pkg::OP_SLTIU:   f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd3);
        rv_decode_pkg::OP_XORI:    f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd4);
        rv_decode_pkg::OP_ORI:     f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd6);
        rv_decode_pkg::OP_ANDI:    f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd7);
        // slli upper bits are not checked
        rv_decode_pkg::OP_SLLI:    f = with_f3(rv_decode_pkg::OPC_OP_IMM, 3'd1);
        rv_decode_pkg::OP_SRLI:    f = with_f7(rv_decode_pkg::OPC_OP_IMM, 3'd5, 1'b0);
        rv_decode_pkg::OP_SRAI:    f = with_f7(rv_decode_pkg::OPC_OP_IMM, 3'd5, 1'b1);
        rv_decode_pkg::OP_ADD:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd0, 1'b0);
        rv_decode_pkg::OP_SUB:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd0, 1'b1);
        rv_decode_pkg::OP_SLL:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd1, 1'b0);
        rv_decode_pkg::OP_SLT:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd2, 1'b0);
        rv_decode_pkg::OP_SLTU:    f = with_f7(rv_decode_pkg::OPC_OP, 3'd3, 1'b0);
        rv_decode_pkg::OP_XOR:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd4, 1'b0);
        rv_decode_pkg::OP_SRL:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd5, 1'b0);
        rv_decode_pkg::OP_SRA:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd5, 1'b1);
        rv_decode_pkg::OP_OR:      f = with_f7(rv_decode_pkg::OPC_OP, 3'd6, 1'b0);
        rv_decode_pkg::OP_AND:     f = with_f7(rv_decode_pkg::OPC_OP, 3'd7, 1'b0);
        rv_decode_pkg::OP_LUI:     f = opc_only(rv_decode_pkg::OPC_LUI);
        rv_decode_pkg::OP_AUIPC:   f = opc_only(rv_decode_pkg::OPC_AUIPC);
        rv_decode_pkg::OP_BEQ:     f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd0);
        rv_decode_pkg::OP_BNE:     f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd1);
        rv_decode_pkg::OP_BLT:     f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd4);
        rv_decode_pkg::OP_BGE:     f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd5);
        rv_decode_pkg::OP_BLTU:    f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd6);
        rv_decode_pkg::OP_BGEU:    f = with_f3(rv_decode_pkg::OPC_BRANCH, 3'd7);
        rv_decode_pkg::OP_JAL:     f = opc_only(rv_decode_pkg::OPC_JAL);
        rv_decode_pkg::OP_JALR:    f = with_f3(rv_decode_pkg::OPC_JALR, 3'd0);
        rv_decode_pkg::OP_FENCE:   f = with_f3(rv_decode_pkg::OPC_MISC_MEM, 3'd0);
        rv_decode_pkg::OP_FENCE_I: f = with_f3(rv_decode_pkg::OPC_MISC_MEM, 3'd1);
        // unused opcode, matches no group
        default:                   f = opc_only(5'b11111);
    endcase
    return f;
endfunction

// random fields, table bits forced on top
function automatic rv_decode_pkg::word_t encode_instr(input rv_decode_pkg::rv_op_e op,
                                                      input logic [31:0] bits);
    op_fmt_t              f;
    rv_decode_pkg::word_t w;
    f = op_fmt(op);
    w = bits;
    w[1:0] = rv_decode_pkg::OPC_FULL;
    w[6:2] = f.opc;
    if (f.use_f3)
        w[14:12] = f.f3;
    if (f.use_f7)
        w[31:25] = f.f7;
    return w;
endfunction

function automatic rv_decode_pkg::word_t random_legal();
    rv_decode_pkg::rv_op_e op;
    op = rv_decode_pkg::rv_op_e'(1 + (next_rand() % 39));
    return encode_instr(op, next_rand());
endfunction

function automatic rv_decode_pkg::rv_op_e expect_op(input rv_decode_pkg::word_t w);
    op_fmt_t               f;
    rv_decode_pkg::rv_op_e op;
    int                    i;
    if (w == '0)
        return rv_decode_pkg::OP_NONE;
    if (w[1:0] != rv_decode_pkg::OPC_FULL)
        return rv_decode_pkg::OP_INVALID;
    for (i = 1; i < 40; i++)
    begin
        op = rv_decode_pkg::rv_op_e'(i);
        f = op_fmt(op);
        if (f.opc == w[6:2] && (!f.use_f3 || f.f3 == w[14:12])
            && (!f.use_f7 || f.f7 == w[31:25]))
            return op;
    end
    return rv_decode_pkg::OP_INVALID;
endfunction

function automatic rv_decode_pkg::word_t expect_imm(input rv_decode_pkg::rv_op_e op,
                                                    input rv_decode_pkg::word_t w);
    op_fmt_t f;
    f = op_fmt(op);
    case (f.opc)
        rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_JALR:
            return {{20{w[31]}}, w[31:20]};
        rv_decode_pkg::OPC_STORE:
            return {{20{w[31]}}, w[31:25], w[11:7]};
        rv_decode_pkg::OPC_BRANCH:
            return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC:
            return {w[31:12], 12'h000};
        rv_decode_pkg::OPC_JAL:
            return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:
            return '0;
    endcase
endfunction

function automatic rv_decode_pkg::decode_ctrl_t expect_ctrl(input rv_decode_pkg::rv_op_e op,
                                                            input rv_decode_pkg::word_t w);
    rv_decode_pkg::decode_ctrl_t c;
    op_fmt_t                     f;
    logic                        ld, st, alu_i, alu_r, br, jal, jalr, upper;
    f = op_fmt(op);
    ld = (f.opc == rv_decode_pkg::OPC_LOAD);
    st = (f.opc == rv_decode_pkg::OPC_STORE);
    alu_i = (f.opc == rv_decode_pkg::OPC_OP_IMM);
    alu_r = (f.opc == rv_decode_pkg::OPC_OP);
    br = (f.opc == rv_decode_pkg::OPC_BRANCH);
    jal = (f.opc == rv_decode_pkg::OPC_JAL);
    jalr = (f.opc == rv_decode_pkg::OPC_JALR);
    upper = (f.opc == rv_decode_pkg::OPC_LUI) || (f.opc == rv_decode_pkg::OPC_AUIPC);
    c = '0;
    c.alu_op = rv_decode_pkg::ALU_ADD;
    if (br)
    begin
        case (f.f3)
            3'd0: c.alu_op = rv_decode_pkg::ALU_EQ;
            3'd1: c.alu_op = rv_decode_pkg::ALU_NE;
            3'd4: c.alu_op = rv_decode_pkg::ALU_LT;
            3'd5: c.alu_op = rv_decode_pkg::ALU_GE;
            3'd6: c.alu_op = rv_decode_pkg::ALU_LTU;
            default: c.alu_op = rv_decode_pkg::ALU_GEU;
        endcase
    end
    else if (alu_i || alu_r)
    begin
        case (f.f3)
            3'd0: c.alu_op = (op == rv_decode_pkg::OP_SUB) ?
                             rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'd1: c.alu_op = rv_decode_pkg::ALU_SLL;
            3'd2: c.alu_op = rv_decode_pkg::ALU_LT;
            3'd3: c.alu_op = rv_decode_pkg::ALU_LTU;
            3'd4: c.alu_op = rv_decode_pkg::ALU_XOR;
            3'd5: c.alu_op = (f.f7 == rv_decode_pkg::F7_ALT) ?
                             rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'd6: c.alu_op = rv_decode_pkg::ALU_OR;
            default: c.alu_op = rv_decode_pkg::ALU_AND;
        endcase
    end
    c.op1_sel = (f.opc == rv_decode_pkg::OPC_AUIPC || jal) ?
                rv_decode_pkg::OP1_PC : rv_decode_pkg::OP1_REG;
    c.op2_sel = (upper || jal || jalr || alu_i || ld || st) ?
                rv_decode_pkg::OP2_IMM : rv_decode_pkg::OP2_REG;
    c.res_src = ld ? rv_decode_pkg::RES_MEM :
                (jal || jalr) ? rv_decode_pkg::RES_PC_P4 : rv_decode_pkg::RES_ALU;
    c.reg_write = ld || alu_i || alu_r || upper || jal || jalr;
    c.mem_read = ld;
    c.mem_write = st;
    c.jump = jal || jalr;
    c.branch = br;
    c.pc_sel = jalr;
    c.funct3 = w[14:12];
    return c;
endfunction

`endif

//--- sim/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

    logic                        i_clk = 1'b0;
    logic                        i_reset;
    logic                        i_stall;
    logic                        i_flush;
    rv_decode_pkg::word_t        i_instr;
    rv_decode_pkg::pc_t          i_pc;
    rv_decode_pkg::reg_idx_t     o_rs1;
    rv_decode_pkg::reg_idx_t     o_rs2;
    rv_decode_pkg::reg_idx_t     o_rd;
    rv_decode_pkg::pc_t          o_pc;
    rv_decode_pkg::word_t        o_imm;
    rv_decode_pkg::decode_ctrl_t o_ctrl;
    logic                        o_inv_instr;

    // what the decode register should hold
    rv_decode_pkg::word_t        exp_instr;
    rv_decode_pkg::pc_t          exp_pc;
    int                          err_count;
    int                          check_count;
    int                          timeout_count;

    `include "tb_decode_model.svh"

    rv_decode rv_decode_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stall     (i_stall),
        .i_flush     (i_flush),
        .i_instr     (i_instr),
        .i_pc        (i_pc),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_rd        (o_rd),
        .o_pc        (o_pc),
        .o_imm       (o_imm),
        .o_ctrl      (o_ctrl),
        .o_inv_instr (o_inv_instr)
    );

    always #10 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp)
        else
        begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_all(input rv_decode_pkg::word_t w, input rv_decode_pkg::pc_t pc);
        rv_decode_pkg::rv_op_e       op;
        rv_decode_pkg::decode_ctrl_t c;
        op = expect_op(w);
        c = expect_ctrl(op, w);
        check_value("o_rd", w[11:7], o_rd);
        check_value("o_rs1", (op == rv_decode_pkg::OP_LUI) ? 5'd0 : w[19:15], o_rs1);
        check_value("o_rs2", w[24:20], o_rs2);
        check_value("o_pc", pc, o_pc);
        check_value("o_imm", expect_imm(op, w), o_imm);
        check_value("o_inv_instr", op == rv_decode_pkg::OP_INVALID, o_inv_instr);
        check_value("o_ctrl.alu_op", c.alu_op, o_ctrl.alu_op);
        check_value("o_ctrl.op1_sel", c.op1_sel, o_ctrl.op1_sel);
        check_value("o_ctrl.op2_sel", c.op2_sel, o_ctrl.op2_sel);
        check_value("o_ctrl.res_src", c.res_src, o_ctrl.res_src);
        check_value("o_ctrl.reg_write", c.reg_write, o_ctrl.reg_write);
        check_value("o_ctrl.mem_read", c.mem_read, o_ctrl.mem_read);
        check_value("o_ctrl.mem_write", c.mem_write, o_ctrl.mem_write);
        check_value("o_ctrl.jump", c.jump, o_ctrl.jump);
        check_value("o_ctrl.branch", c.branch, o_ctrl.branch);
        check_value("o_ctrl.pc_sel", c.pc_sel, o_ctrl.pc_sel);
        check_value("o_ctrl.funct3", c.funct3, o_ctrl.funct3);
    endtask

    // called on a falling edge, checks one rising edge later
    task automatic step(input logic stall, input logic flush,
                        input rv_decode_pkg::word_t instr, input rv_decode_pkg::pc_t pc);
        i_stall = stall;
        i_flush = flush;
        i_instr = instr;
        i_pc = pc;
        if (flush)
        begin
            exp_instr = '0;
            exp_pc = '0;
        end
        else if (!stall)
        begin
            exp_instr = instr;
            exp_pc = pc;
        end
        @(negedge i_clk);
        compare_all(exp_instr, exp_pc);
    endtask

    function automatic logic bubble_seen();
        return (o_pc === '0) && (o_imm === '0) && (o_inv_instr === 1'b0)
            && (o_ctrl.reg_write === 1'b0) && (o_ctrl.mem_read === 1'b0)
            && (o_ctrl.mem_write === 1'b0) && (o_ctrl.jump === 1'b0)
            && (o_ctrl.branch === 1'b0) && (o_ctrl.pc_sel === 1'b0);
    endfunction

    task automatic wait_for_bubble(input int limit);
        int n;
        n = 0;
        while (!bubble_seen() && n < limit)
        begin
            @(negedge i_clk);
            n++;
        end
        if (!bubble_seen())
        begin
            $display("timeout: decode outputs were not cleared by reset");
            timeout_count++;
        end
    endtask

    initial
    begin
        rv_decode_pkg::word_t w;
        int                   k;
        int                   n;
        int                   round;
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_instr = '0;
        i_pc = '0;
        rng_state = LCG_SEED;
        exp_instr = '0;
        exp_pc = '0;
        err_count = 0;
        check_count = 0;
        timeout_count = 0;

        repeat (5) @(negedge i_clk);
        wait_for_bubble(10);
        i_reset = 1'b0;
        compare_all(exp_instr, exp_pc);

        // legal instructions back to back
        for (n = 0; n < 300; n++)
        begin
            w = random_legal();
            step(1'b0, 1'b0, w, rv_decode_pkg::pc_t'(next_rand()));
        end

        // raw words, every other one with the 32-bit low bits forced
        for (n = 0; n < 200; n++)
        begin
            w = next_rand();
            if (n[0])
                w[1:0] = 2'b11;
            step(1'b0, 1'b0, w, rv_decode_pkg::pc_t'(next_rand()));
        end

        // stall holds, flush clears even under stall
        for (round = 0; round < 40; round++)
        begin
            step(1'b0, 1'b0, random_legal(), rv_decode_pkg::pc_t'(next_rand()));
            k = 1 + (next_rand() % 5);
            repeat (k)
                step(1'b1, 1'b0, random_legal(), rv_decode_pkg::pc_t'(next_rand()));
            step(round[0], 1'b1, random_legal(), rv_decode_pkg::pc_t'(next_rand()));
        end

        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
hdl/rv_decode_pkg.sv
hdl/rv_instr_latch.sv
hdl/rv_instr_classify.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_gen.sv
hdl/rv_decode.sv
sim/tb_rv_decode.sv

//--- Bender.yml
package:
  name: rv_decode

sources:
  - files:
      - hdl/rv_decode_pkg.sv
      - hdl/rv_instr_latch.sv
      - hdl/rv_instr_classify.sv
      - hdl/rv_imm_gen.sv
      - hdl/rv_ctrl_gen.sv
      - hdl/rv_decode.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_decode.sv
